/* rtl/board_pkg.sv */
// Segment patterns are active high with bit 7 as decimal point; periods are board defaults
`default_nettype none

package board_pkg;

    localparam int N_DIGITS     = 8;
    localparam int DIGIT_BITS   = $clog2(N_DIGITS);
    localparam int MARQUEE_LEN  = 16;
    localparam int MARQUEE_BITS = $clog2(MARQUEE_LEN);

    typedef logic [31:0]         word_t;
    typedef logic [7:0]          byte_t;
    typedef logic [7:0]          seg_t;   // {dp, a, b, c, d, e, f, g}
    typedef logic [N_DIGITS-1:0] an_t;    // Active low, one bit per digit
    typedef logic [2:0]          rgb_t;   // {blue, green, red}

    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3                     // Code 2 is reserved
    } priv_t;

    localparam rgb_t RGB_BLUE  = 3'b100;
    localparam rgb_t RGB_GREEN = 3'b010;
    localparam rgb_t RGB_RED   = 3'b001;

    // Hex digits 0..F
    localparam seg_t SEG_FONT_HEX [16] = '{
        8'h7e, 8'h30, 8'h6d, 8'h79,
        8'h33, 8'h5b, 8'h5f, 8'h70,
        8'h7f, 8'h7b, 8'h77, 8'h1f,
        8'h4e, 8'h3d, 8'h4f, 8'h47
    };

    // Digit 0 is rightmost, so the board reads "ArchProc"
    localparam seg_t SEG_BANNER [N_DIGITS] = '{
        8'h0d, 8'h1d, 8'h05, 8'h67,       // c o r P
        8'h17, 8'h0d, 8'h05, 8'h77        // h c r A
    };

    localparam seg_t SEG_MARQUEE [MARQUEE_LEN] = '{
        8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00,
        8'h0e, 8'h1d, 8'h7d, 8'h3d,       // L o a d
        8'h10, 8'h15, 8'hfb,              // i n g
        8'h80, 8'h80                      // Trailing dots
    };

    // Breathing LED
    localparam int PWM_BITS       = 12;
    localparam int BLINK_BITS     = 4;
    localparam int BREATH_START_B = 0;
    localparam int BREATH_START_G = 64;
    localparam int BREATH_START_R = 512;
    localparam int BREATH_STEP_B  = 2;
    localparam int BREATH_STEP_G  = 3;
    localparam int BREATH_STEP_R  = 5;

    localparam int SCAN_DIV_DEFAULT      = 16000;       // Dwell per digit at 8 MHz
    localparam int MARQUEE_LOG2_DEFAULT  = 25;
    localparam int HEARTBEAT_DIV_DEFAULT = 32000000;

endpackage

`default_nettype wire

/* rtl/display_source.sv */
// Every kbd/mouse strobe is taken; display value lags buttons and history by one cycle
`timescale 1ns/1ps
`default_nettype none

module display_source (
    input  wire                   CORE_CLK,
    input  wire                   CORE_RST_X,
    input  wire                   i_kbd_we,
    input  wire board_pkg::byte_t i_kbd_data,
    input  wire                   i_mouse_we,
    input  wire board_pkg::byte_t i_mouse_data,
    input  wire                   i_btn_u,
    input  wire                   i_btn_d,
    input  wire                   i_btn_c,
    input  wire                   i_btn_l,
    input  wire                   i_btn_r,
    input  wire board_pkg::word_t i_core_pc,
    input  wire board_pkg::word_t i_core_ir,
    output board_pkg::word_t      o_disp_value
);

    board_pkg::word_t history;    // {mouse prev, mouse new, key prev, key new}
    board_pkg::word_t sel_value;

    // Two-deep byte history per source
    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            history <= '0;
        end else begin
            if (i_kbd_we) begin
                history[15:0] <= {history[7:0], i_kbd_data};
            end
            if (i_mouse_we) begin
                history[31:16] <= {history[23:16], i_mouse_data};
            end
        end
    end

    always_comb begin
        if (i_btn_u || i_btn_d || i_btn_c) begin
            sel_value = '0;                 // Blank view wins over left/right
        end else if (i_btn_l) begin
            sel_value = i_core_pc;
        end else if (i_btn_r) begin
            sel_value = i_core_ir;
        end else begin
            sel_value = history;
        end
    end

    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            o_disp_value <= '0;
        end else begin
            o_disp_value <= sel_value;
        end
    end

endmodule

`default_nettype wire

/* rtl/seg7_scanner.sv */
// Candidate patterns are sampled once per dwell; MARQUEE_LOG2 must be at least 1
`timescale 1ns/1ps
`default_nettype none

module seg7_scanner #(
    parameter int SCAN_DIV     = board_pkg::SCAN_DIV_DEFAULT,
    parameter int MARQUEE_LOG2 = board_pkg::MARQUEE_LOG2_DEFAULT
) (
    input  wire                   CORE_CLK,
    input  wire                   CORE_RST_X,
    input  wire board_pkg::word_t i_disp_value,
    input  wire                   i_loading,
    output board_pkg::an_t        o_an_next,
    output board_pkg::seg_t       o_hex_seg,
    output board_pkg::seg_t       o_banner_seg,
    output board_pkg::seg_t       o_marquee_seg
);

    localparam int DWELL_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

    logic [DWELL_W-1:0]                dwell_cnt;
    logic [board_pkg::DIGIT_BITS-1:0]  digit;
    logic [MARQUEE_LOG2-1:0]           step_cnt;     // Loading cycles, wraps
    logic [board_pkg::MARQUEE_BITS-1:0] mq_offset;
    logic [board_pkg::MARQUEE_BITS-1:0] mq_index;
    logic [3:0]                        nibble;
    logic                              scan_tick;

    assign scan_tick = (dwell_cnt == '0);
    assign nibble    = i_disp_value[digit*4 +: 4];

    // Leftmost digit shows the entry at the offset, the text moves left
    assign mq_index  = mq_offset + board_pkg::MARQUEE_BITS'(board_pkg::N_DIGITS - 1)
                     - board_pkg::MARQUEE_BITS'(digit);

    // Dwell counter
    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            dwell_cnt <= '0;
        end else if (dwell_cnt == DWELL_W'(SCAN_DIV - 1)) begin
            dwell_cnt <= '0;
        end else begin
            dwell_cnt <= dwell_cnt + 1'b1;
        end
    end

    // Digit select and per-digit patterns
    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            digit         <= '0;
            o_an_next     <= '1;                  // No digit lit
            o_hex_seg     <= '0;
            o_banner_seg  <= '0;
            o_marquee_seg <= '0;
        end else if (scan_tick) begin
            digit         <= digit + 1'b1;
            o_an_next     <= ~(board_pkg::an_t'(1) << digit);
            o_hex_seg     <= board_pkg::SEG_FONT_HEX[nibble];
            o_banner_seg  <= board_pkg::SEG_BANNER[digit];
            o_marquee_seg <= board_pkg::SEG_MARQUEE[mq_index];
        end
    end

    // Marquee scroll, only advances while a load runs
    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            step_cnt  <= '0;
            mq_offset <= '0;
        end else if (i_loading) begin
            step_cnt <= step_cnt + 1'b1;
            if (step_cnt == '0) begin
                mq_offset <= mq_offset + 1'b1;  // First step on first loading cycle
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/status_leds.sv */
// Breathing and blink counters free-run from reset; a reserved privilege code shows dark
`timescale 1ns/1ps
`default_nettype none

module status_leds #(
    parameter int HEARTBEAT_DIV = board_pkg::HEARTBEAT_DIV_DEFAULT
) (
    input  wire                   CORE_CLK,
    input  wire                   CORE_RST_X,
    input  wire                   i_boot_wait,
    input  wire                   i_init_done,
    input  wire board_pkg::priv_t i_priv,
    output board_pkg::rgb_t       o_rgb,
    output logic                  o_heartbeat
);

    localparam int HB_W    = (HEARTBEAT_DIV > 1) ? $clog2(HEARTBEAT_DIV) : 1;
    localparam int PWM_W   = board_pkg::PWM_BITS;
    localparam int PHASE_W = PWM_W + 1;          // Top bit flips the duty direction
    localparam int N_CH    = $bits(board_pkg::rgb_t);

    // Channel 0 is red, matching the rgb_t bit order
    localparam logic [PHASE_W-1:0] PHASE_START [N_CH] = '{
        PHASE_W'(board_pkg::BREATH_START_R),
        PHASE_W'(board_pkg::BREATH_START_G),
        PHASE_W'(board_pkg::BREATH_START_B)
    };
    localparam logic [PHASE_W-1:0] PHASE_STEP [N_CH] = '{
        PHASE_W'(board_pkg::BREATH_STEP_R),
        PHASE_W'(board_pkg::BREATH_STEP_G),
        PHASE_W'(board_pkg::BREATH_STEP_B)
    };

    logic [PWM_W-1:0]                pwm_cnt;
    logic [PHASE_W-1:0]              phase [N_CH];
    logic [board_pkg::BLINK_BITS-1:0] blink_cnt;
    logic [HB_W-1:0]                 hb_cnt;
    board_pkg::rgb_t                 breath;
    board_pkg::rgb_t                 priv_rgb;

    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            pwm_cnt   <= '0;
            blink_cnt <= '0;
            for (int ch = 0; ch < N_CH; ch++) begin
                phase[ch] <= PHASE_START[ch];
            end
        end else begin
            pwm_cnt   <= pwm_cnt + 1'b1;
            blink_cnt <= blink_cnt + 1'b1;
            if (pwm_cnt == '0) begin
                for (int ch = 0; ch < N_CH; ch++) begin
                    phase[ch] <= phase[ch] + PHASE_STEP[ch];
                end
            end
        end
    end

    always_comb begin
        for (int ch = 0; ch < N_CH; ch++) begin
            if (phase[ch][PHASE_W-1]) begin
                breath[ch] = (phase[ch][PWM_W-1:0] < pwm_cnt);   // Fading out
            end else begin
                breath[ch] = (phase[ch][PWM_W-1:0] >= pwm_cnt);
            end
        end
    end

    always_comb begin
        case (i_priv)
            board_pkg::PRIV_U: priv_rgb = board_pkg::RGB_BLUE;
            board_pkg::PRIV_S: priv_rgb = board_pkg::RGB_GREEN;
            board_pkg::PRIV_M: priv_rgb = board_pkg::RGB_RED;
            default:           priv_rgb = '0;
        endcase
    end

    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            o_rgb <= '0;
        end else if (i_boot_wait) begin
            o_rgb <= breath;
        end else if (!i_init_done || (blink_cnt != '0)) begin
            o_rgb <= '0;                          // Short blink, one cycle per period
        end else begin
            o_rgb <= priv_rgb;
        end
    end

    // Heartbeat
    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            hb_cnt      <= '0;
            o_heartbeat <= 1'b0;
        end else begin
            hb_cnt <= (hb_cnt == HB_W'(HEARTBEAT_DIV - 1)) ? '0 : hb_cnt + 1'b1;
            if (hb_cnt == '0) begin
                o_heartbeat <= ~o_heartbeat;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/seg7_driver.sv */
// Outputs are active low for a common-anode board and update on the same edge
`timescale 1ns/1ps
`default_nettype none

module seg7_driver (
    input  wire                   CORE_CLK,
    input  wire                   CORE_RST_X,
    input  wire board_pkg::an_t   i_an_next,
    input  wire board_pkg::seg_t  i_hex_seg,
    input  wire board_pkg::seg_t  i_banner_seg,
    input  wire board_pkg::seg_t  i_marquee_seg,
    input  wire                   i_loading,
    input  wire                   i_init_done,
    output board_pkg::an_t        o_an,
    output board_pkg::seg_t       o_sg
);

    board_pkg::seg_t mode_seg;

    // Loading marquee takes priority over the banner
    always_comb begin
        if (i_loading) begin
            mode_seg = i_marquee_seg;
        end else if (!i_init_done) begin
            mode_seg = i_banner_seg;
        end else begin
            mode_seg = i_hex_seg;
        end
    end

    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            o_an <= '1;
            o_sg <= '1;                           // All segments dark
        end else begin
            o_an <= i_an_next;
            o_sg <= ~mode_seg;
        end
    end

endmodule

`default_nettype wire

/* rtl/board_status_top.sv */
// Display is two cycles behind a dwell start; periods may be shortened for simulation
`timescale 1ns/1ps
`default_nettype none

module board_status_top #(
    parameter int SCAN_DIV      = board_pkg::SCAN_DIV_DEFAULT,
    parameter int MARQUEE_LOG2  = board_pkg::MARQUEE_LOG2_DEFAULT,
    parameter int HEARTBEAT_DIV = board_pkg::HEARTBEAT_DIV_DEFAULT
) (
    input  wire                   CORE_CLK,
    input  wire                   CORE_RST_X,
    input  wire                   i_kbd_we,
    input  wire board_pkg::byte_t i_kbd_data,
    input  wire                   i_mouse_we,
    input  wire board_pkg::byte_t i_mouse_data,
    input  wire                   i_btn_u,
    input  wire                   i_btn_d,
    input  wire                   i_btn_c,
    input  wire                   i_btn_l,
    input  wire                   i_btn_r,
    input  wire board_pkg::word_t i_core_pc,
    input  wire board_pkg::word_t i_core_ir,
    input  wire                   i_loading,
    input  wire                   i_init_done,
    input  wire                   i_boot_wait,
    input  wire board_pkg::priv_t i_priv,
    output board_pkg::seg_t       o_sg,
    output board_pkg::an_t        o_an,
    output board_pkg::rgb_t       o_rgb,
    output logic                  o_heartbeat
);

    board_pkg::word_t disp_value;
    board_pkg::an_t   an_next;
    board_pkg::seg_t  hex_seg;
    board_pkg::seg_t  banner_seg;
    board_pkg::seg_t  marquee_seg;

    display_source u_display_source (
        .CORE_CLK     (CORE_CLK),
        .CORE_RST_X   (CORE_RST_X),
        .i_kbd_we     (i_kbd_we),
        .i_kbd_data   (i_kbd_data),
        .i_mouse_we   (i_mouse_we),
        .i_mouse_data (i_mouse_data),
        .i_btn_u      (i_btn_u),
        .i_btn_d      (i_btn_d),
        .i_btn_c      (i_btn_c),
        .i_btn_l      (i_btn_l),
        .i_btn_r      (i_btn_r),
        .i_core_pc    (i_core_pc),
        .i_core_ir    (i_core_ir),
        .o_disp_value (disp_value)
    );

    seg7_scanner #(
        .SCAN_DIV     (SCAN_DIV),
        .MARQUEE_LOG2 (MARQUEE_LOG2)
    ) u_seg7_scanner (
        .CORE_CLK      (CORE_CLK),
        .CORE_RST_X    (CORE_RST_X),
        .i_disp_value  (disp_value),
        .i_loading     (i_loading),
        .o_an_next     (an_next),
        .o_hex_seg     (hex_seg),
        .o_banner_seg  (banner_seg),
        .o_marquee_seg (marquee_seg)
    );

    seg7_driver u_seg7_driver (
        .CORE_CLK      (CORE_CLK),
        .CORE_RST_X    (CORE_RST_X),
        .i_an_next     (an_next),
        .i_hex_seg     (hex_seg),
        .i_banner_seg  (banner_seg),
        .i_marquee_seg (marquee_seg),
        .i_loading     (i_loading),
        .i_init_done   (i_init_done),
        .o_an          (o_an),
        .o_sg          (o_sg)
    );

    status_leds #(
        .HEARTBEAT_DIV (HEARTBEAT_DIV)
    ) u_status_leds (
        .CORE_CLK    (CORE_CLK),
        .CORE_RST_X  (CORE_RST_X),
        .i_boot_wait (i_boot_wait),
        .i_init_done (i_init_done),
        .i_priv      (i_priv),
        .o_rgb       (o_rgb),
        .o_heartbeat (o_heartbeat)
    );

endmodule

`default_nettype wire

/* sim/tb_clock_gen.sv */
// Clock runs from time zero; reset is held low for RESET_CYCLES edges, released on a rising edge
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 4,     // 8 ns period
    parameter int RESET_CYCLES = 8
) (
    output logic CORE_CLK,
    output logic CORE_RST_X
);

    initial begin
        CORE_CLK = 1'b0;
        forever begin
            #(HALF_PERIOD) CORE_CLK = ~CORE_CLK;
        end
    end

    initial begin
        CORE_RST_X = 1'b0;
        repeat (RESET_CYCLES) @(posedge CORE_CLK);
        CORE_RST_X <= 1'b1;             // Seen high from the next edge on
    end

endmodule

`default_nettype wire

/* sim/tb_board_status.sv */
// Uses shortened periods (scan 4, marquee step 8, heartbeat 16); the first failing check ends the run
`timescale 1ns/1ps
`default_nettype none

module tb_board_status;

    localparam int SCAN_DIV       = 4;
    localparam int MARQUEE_LOG2   = 3;
    localparam int HEARTBEAT_DIV  = 16;
    localparam int SCAN_CYCLES    = board_pkg::N_DIGITS * SCAN_DIV;
    localparam int SETTLE_CYCLES  = 2 * SCAN_DIV + 4;
    localparam int BREATH_CYCLES  = 1 << board_pkg::PWM_BITS;
    localparam int TIMEOUT_CYCLES = 20000;      // About four times the whole run
    localparam int MODE_HEX       = 0;
    localparam int MODE_BANNER    = 1;
    localparam int MODE_MARQUEE   = 2;

    wire CORE_CLK;
    wire CORE_RST_X;

    logic             i_kbd_we;
    board_pkg::byte_t i_kbd_data;
    logic             i_mouse_we;
    board_pkg::byte_t i_mouse_data;
    logic             i_btn_u;
    logic             i_btn_d;
    logic             i_btn_c;
    logic             i_btn_l;
    logic             i_btn_r;
    board_pkg::word_t i_core_pc;
    board_pkg::word_t i_core_ir;
    logic             i_loading;
    logic             i_init_done;
    logic             i_boot_wait;
    board_pkg::priv_t i_priv;
    board_pkg::seg_t  o_sg;
    board_pkg::an_t   o_an;
    board_pkg::rgb_t  o_rgb;
    logic             o_heartbeat;

    // Expectation shared with the scan checker
    int               exp_mode       = MODE_BANNER;
    board_pkg::word_t exp_value      = '0;
    logic             chk_en         = 1'b0;
    string            test_name      = "idle";
    int               digits_checked = 0;
    board_pkg::word_t hist_model     = '0;    // Predicted byte history
    int               load_count     = 0;
    int               load_hist [$];           // One entry per edge with the newest first
    int               cycle_count    = 0;

    board_pkg::an_t   last_an      = '1;
    board_pkg::seg_t  last_sg      = '1;
    board_pkg::seg_t  last_exp_sg  = '1;
    logic             last_chk     = 1'b0;
    string            last_name    = "idle";
    logic [2:0]       next_digit   = '0;
    logic             scan_started = 1'b0;
    int               dwell_len    = 0;
    logic             hb_last      = 1'b0;
    logic             hb_seen      = 1'b0;
    int               hb_age       = 0;
    int               hb_toggles   = 0;

    tb_clock_gen u_clock_gen (
        .CORE_CLK   (CORE_CLK),
        .CORE_RST_X (CORE_RST_X)
    );

    board_status_top #(
        .SCAN_DIV      (SCAN_DIV),
        .MARQUEE_LOG2  (MARQUEE_LOG2),
        .HEARTBEAT_DIV (HEARTBEAT_DIV)
    ) board_status_top_i (
        .CORE_CLK     (CORE_CLK),
        .CORE_RST_X   (CORE_RST_X),
        .i_kbd_we     (i_kbd_we),
        .i_kbd_data   (i_kbd_data),
        .i_mouse_we   (i_mouse_we),
        .i_mouse_data (i_mouse_data),
        .i_btn_u      (i_btn_u),
        .i_btn_d      (i_btn_d),
        .i_btn_c      (i_btn_c),
        .i_btn_l      (i_btn_l),
        .i_btn_r      (i_btn_r),
        .i_core_pc    (i_core_pc),
        .i_core_ir    (i_core_ir),
        .i_loading    (i_loading),
        .i_init_done  (i_init_done),
        .i_boot_wait  (i_boot_wait),
        .i_priv       (i_priv),
        .o_sg         (o_sg),
        .o_an         (o_an),
        .o_rgb        (o_rgb),
        .o_heartbeat  (o_heartbeat)
    );

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_seg(input string name, input board_pkg::seg_t expected,
                             input board_pkg::seg_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("mismatch %s: expected %h, actual %h",
                                     name, expected, actual));
        end
    endtask

    task automatic check_an(input string name, input board_pkg::an_t expected,
                            input board_pkg::an_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("mismatch %s: expected %b, actual %b",
                                     name, expected, actual));
        end
    endtask

    task automatic check_rgb(input string name, input board_pkg::rgb_t expected,
                             input board_pkg::rgb_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("mismatch %s: expected %b, actual %b",
                                     name, expected, actual));
        end
    endtask

    task automatic check_level(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            report_failure($sformatf("mismatch %s: expected %b, actual %b",
                                     name, expected, actual));
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            report_failure($sformatf("mismatch %s: expected %0d, actual %0d",
                                     name, expected, actual));
        end
    endtask

    // Offset after n loading cycles with the first step on the first one
    function automatic logic [3:0] marquee_offset(input int n_loading);
        return 4'((n_loading + (1 << MARQUEE_LOG2) - 1) >> MARQUEE_LOG2);
    endfunction

    function automatic logic [2:0] digit_of(input board_pkg::an_t an);
        logic [2:0] d;
        d = '0;
        for (int i = 0; i < board_pkg::N_DIGITS; i++) begin
            if (an == ~(board_pkg::an_t'(1) << i)) begin
                d = 3'(i);
            end
        end
        return d;
    endfunction

    // Active-low segments expected on one digit
    function automatic board_pkg::seg_t expected_seg(input int mode, input board_pkg::word_t value,
                                                     input logic [2:0] digit,
                                                     input logic [3:0] offset);
        board_pkg::seg_t pattern;
        logic [3:0]      idx;
        case (mode)
            MODE_MARQUEE: begin
                idx     = offset + 4'(board_pkg::N_DIGITS - 1 - int'(digit));
                pattern = board_pkg::SEG_MARQUEE[idx];
            end
            MODE_BANNER: pattern = board_pkg::SEG_BANNER[digit];
            default:     pattern = board_pkg::SEG_FONT_HEX[4'(value >> (4 * int'(digit)))];
        endcase
        return ~pattern;
    endfunction

    function automatic board_pkg::rgb_t expected_rgb(input board_pkg::priv_t priv);
        case (priv)
            board_pkg::PRIV_U: return 3'b100;     // Blue
            board_pkg::PRIV_S: return 3'b010;     // Green
            board_pkg::PRIV_M: return 3'b001;     // Red
            default:           return '0;
        endcase
    endfunction

    // Loading cycles seen by the DUT up to each edge
    always @(posedge CORE_CLK) begin
        if (CORE_RST_X && i_loading) begin
            load_count = load_count + 1;
        end
        load_hist.push_front(load_count);
        if (load_hist.size() > 8) begin
            void'(load_hist.pop_back());
        end
    end

    always @(posedge CORE_CLK) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            report_failure($sformatf("timeout: tests did not finish in %0d cycles", cycle_count));
        end
    end

    // A change of o_an closes a dwell; the values kept from its last cycle are compared
    always @(negedge CORE_CLK) begin
        if (CORE_RST_X) begin
            if (o_an !== last_an) begin
                if (last_an !== '1) begin
                    check_an("scan order", ~(board_pkg::an_t'(1) << next_digit), last_an);
                    check_count("dwell length", SCAN_DIV, dwell_len);
                    next_digit = next_digit + 1'b1;
                    if (last_chk) begin
                        check_seg(last_name, last_exp_sg, last_sg);
                        digits_checked = digits_checked + 1;
                    end
                end
                dwell_len = 0;
            end
            dwell_len = dwell_len + 1;
            if (o_an !== '1) begin
                scan_started = 1'b1;
            end
            if (scan_started) begin
                if ($countones(~o_an) != 1) begin
                    report_failure("o_an does not select exactly one digit while scanning");
                end
                // Offset as the scanner saw it at the dwell start five edges back
                last_exp_sg = expected_seg(exp_mode, exp_value, digit_of(o_an),
                                           marquee_offset(load_hist[5]));
            end
            last_an   = o_an;
            last_sg   = o_sg;
            last_chk  = chk_en;
            last_name = test_name;
        end
    end

    always @(negedge CORE_CLK) begin
        if (CORE_RST_X) begin
            hb_age = hb_age + 1;
            if (o_heartbeat !== hb_last) begin
                if (hb_seen) begin
                    check_count("heartbeat period", HEARTBEAT_DIV, hb_age);
                end
                hb_seen    = 1'b1;
                hb_age     = 0;
                hb_last    = o_heartbeat;
                hb_toggles = hb_toggles + 1;
            end
        end
    end

    // Settle and then check two full scans against the given mode
    task automatic display_window(input string name, input int mode, input board_pkg::word_t value);
        int start_count;
        repeat (SETTLE_CYCLES) @(posedge CORE_CLK);
        test_name   = name;
        exp_mode    = mode;
        exp_value   = value;
        start_count = digits_checked;
        chk_en      = 1'b1;
        repeat (2 * SCAN_CYCLES) @(posedge CORE_CLK);
        chk_en = 1'b0;
        if (digits_checked - start_count < 2 * board_pkg::N_DIGITS - 1) begin
            report_failure($sformatf("%s: too few digits were checked", name));
        end
    endtask

    task automatic send_input_bytes(input int count);
        logic             kbd_we;
        logic             mouse_we;
        board_pkg::byte_t kbd_byte;
        board_pkg::byte_t mouse_byte;
        for (int i = 0; i < count; i++) begin
            kbd_we     = 1'($urandom);
            mouse_we   = 1'($urandom);
            kbd_byte   = 8'($urandom);
            mouse_byte = 8'($urandom);
            @(posedge CORE_CLK);
            i_kbd_we     <= kbd_we;
            i_kbd_data   <= kbd_byte;
            i_mouse_we   <= mouse_we;
            i_mouse_data <= mouse_byte;
            if (kbd_we) begin
                hist_model[15:0] = {hist_model[7:0], kbd_byte};
            end
            if (mouse_we) begin
                hist_model[31:16] = {hist_model[23:16], mouse_byte};
            end
        end
        @(posedge CORE_CLK);
        i_kbd_we   <= 1'b0;
        i_mouse_we <= 1'b0;
    endtask

    task automatic press_buttons(input logic u, input logic d, input logic c,
                                 input logic l, input logic r);
        @(posedge CORE_CLK);
        i_btn_u <= u;
        i_btn_d <= d;
        i_btn_c <= c;
        i_btn_l <= l;
        i_btn_r <= r;
    endtask

    // Privilege colour is lit on exactly one cycle of every 16
    task automatic blink_check(input string name, input board_pkg::priv_t priv);
        int n_on;
        n_on = 0;
        @(posedge CORE_CLK);
        i_priv <= priv;
        repeat (4) @(posedge CORE_CLK);
        repeat (1 << board_pkg::BLINK_BITS) begin
            @(negedge CORE_CLK);
            if (o_rgb !== '0) begin
                n_on = n_on + 1;
                check_rgb(name, expected_rgb(priv), o_rgb);
            end
        end
        check_count({name, " lit cycles"}, (expected_rgb(priv) == '0) ? 0 : 1, n_on);
    endtask

    task automatic breathing_check();
        board_pkg::rgb_t seen_on;
        board_pkg::rgb_t seen_off;
        seen_on  = '0;
        seen_off = '0;
        @(posedge CORE_CLK);
        i_boot_wait <= 1'b1;
        repeat (2) @(posedge CORE_CLK);
        repeat (BREATH_CYCLES) begin
            @(negedge CORE_CLK);
            seen_on  = seen_on | o_rgb;
            seen_off = seen_off | ~o_rgb;
        end
        check_rgb("breathing channels on", 3'b111, seen_on);
        check_rgb("breathing channels off", 3'b111, seen_off);
        @(posedge CORE_CLK);
        i_boot_wait <= 1'b0;
    endtask

    initial begin
        void'($urandom(67983));
        i_kbd_we     = 1'b0;
        i_kbd_data   = '0;
        i_mouse_we   = 1'b0;
        i_mouse_data = '0;
        i_btn_u      = 1'b0;
        i_btn_d      = 1'b0;
        i_btn_c      = 1'b0;
        i_btn_l      = 1'b0;
        i_btn_r      = 1'b0;
        i_core_pc    = '0;
        i_core_ir    = '0;
        i_loading    = 1'b0;
        i_init_done  = 1'b0;
        i_boot_wait  = 1'b0;
        i_priv       = board_pkg::PRIV_U;

        // Reset state during reset and on the first edges after it
        repeat (2) @(negedge CORE_CLK);
        check_an("reset an", '1, o_an);
        check_seg("reset sg", '1, o_sg);
        wait (CORE_RST_X === 1'b1);
        @(negedge CORE_CLK);
        check_rgb("reset rgb", '0, o_rgb);
        check_level("reset heartbeat", 1'b0, o_heartbeat);
        @(negedge CORE_CLK);
        check_an("an after reset", '1, o_an);
        check_seg("sg after reset", '1, o_sg);
        check_rgb("rgb after reset", '0, o_rgb);

        display_window("banner", MODE_BANNER, '0);

        send_input_bytes(12);
        @(posedge CORE_CLK);
        i_init_done <= 1'b1;
        display_window("history", MODE_HEX, hist_model);

        @(posedge CORE_CLK);
        i_core_pc <= $urandom;
        i_core_ir <= $urandom;
        @(posedge CORE_CLK);
        press_buttons(1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
        display_window("button left", MODE_HEX, i_core_pc);
        press_buttons(1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
        display_window("button right", MODE_HEX, i_core_ir);
        press_buttons(1'b0, 1'b0, 1'b0, 1'b1, 1'b1);
        display_window("button left and right", MODE_HEX, i_core_pc);
        press_buttons(1'b1, 1'b0, 1'b0, 1'b1, 1'b0);
        display_window("button up", MODE_HEX, '0);
        press_buttons(1'b0, 1'b1, 1'b0, 1'b0, 1'b1);
        display_window("button down", MODE_HEX, '0);
        press_buttons(1'b0, 1'b0, 1'b1, 1'b1, 1'b1);
        display_window("button centre", MODE_HEX, '0);
        press_buttons(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);

        // Marquee wins over both the hex view and the banner
        @(posedge CORE_CLK);
        i_loading <= 1'b1;
        display_window("marquee with init done", MODE_MARQUEE, '0);
        @(posedge CORE_CLK);
        i_init_done <= 1'b0;
        display_window("marquee before init", MODE_MARQUEE, '0);
        @(posedge CORE_CLK);
        i_loading   <= 1'b0;
        i_init_done <= 1'b1;
        display_window("hex after load", MODE_HEX, hist_model);

        blink_check("privilege U", board_pkg::PRIV_U);
        blink_check("privilege S", board_pkg::PRIV_S);
        blink_check("privilege M", board_pkg::PRIV_M);
        blink_check("reserved privilege", board_pkg::priv_t'(2'd2));
        breathing_check();

        if (hb_toggles < 3) begin
            report_failure("heartbeat did not toggle during the run");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* list.f */
rtl/board_pkg.sv
rtl/display_source.sv
rtl/seg7_scanner.sv
rtl/status_leds.sv
rtl/seg7_driver.sv
rtl/board_status_top.sv
sim/tb_clock_gen.sv
sim/tb_board_status.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; exit status is the simulator's
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    --top-module tb_board_status \
    --Mdir obj_dir \
    -o tb_board_status \
    -f list.f

./obj_dir/tb_board_status
